// ==== design/dram_params.svh ====
// sizes and latencies of the ddr4_lite chip model
// included by the package and by every module that needs a size or a latency
`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// data and address pins
`define DRAM_DQ_WIDTH 16
`define DRAM_ADDR_BITS 17

// array geometry, kept small for simulation
`define DRAM_ROW_BITS 6
`define DRAM_COL_BITS 4
`define DRAM_NUM_BANKS 4
`define DRAM_BURST_LEN 8

// latencies in clk_in cycles, scaled down from real ddr4
`define DRAM_ACT_LATENCY 4
`define DRAM_CAS_LATENCY 6
`define DRAM_PRE_LATENCY 3

`endif

// ==== design/dram_pkg.sv ====
// shared types of the ddr4_lite chip model
// modules pull these in with a wildcard import in their header
`default_nettype none

`include "dram_params.svh"

package dram_pkg;

    typedef logic [`DRAM_DQ_WIDTH-1:0] dq_t;                      // one data or mask beat
    typedef logic [`DRAM_ROW_BITS-1:0] row_t;
    typedef logic [`DRAM_COL_BITS-1:0] col_t;
    typedef logic [$clog2(`DRAM_BURST_LEN)-1:0] beat_t;           // position inside a burst
    typedef logic [`DRAM_NUM_BANKS-1:0] bank_sel_t;               // one-hot, bit per bank
    typedef logic [`DRAM_BURST_LEN-1:0][`DRAM_DQ_WIDTH-1:0] burst_t; // index k holds beat k

    // decoded command handed from the decoder to the banks
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_ACTIVATE,
        CMD_READ,
        CMD_WRITE,
        CMD_PRECHARGE
    } bank_cmd_t;

    typedef enum logic [2:0] {
        BANK_CLOSED,
        BANK_ACTIVATING,
        BANK_OPEN,
        BANK_READING,
        BANK_WRITING,
        BANK_PRECHARGING
    } bank_state_t;

endpackage

`default_nettype wire

// ==== design/dram_cmd_decoder.sv ====
// command front end of the chip
// samples cs_n/act_n/addr/ba each edge and registers a one-hot bank command
// with its row or column, valid for exactly one cycle per accepted command
`timescale 1ns/1ps
`default_nettype none

`include "dram_params.svh"

module dram_cmd_decoder import dram_pkg::*; (
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       cs_n,     // chip select, active low
    input  logic                       act_n,    // activate, active low
    input  logic [`DRAM_ADDR_BITS-1:0] addr,     // 16:14 carry ras/cas/we when act_n high
    input  logic [1:0]                 ba,       // bank address
    output bank_sel_t                  cmd_sel,
    output bank_cmd_t                  cmd,
    output row_t                       cmd_row,
    output col_t                       cmd_col
);

    logic [5:0] cmd_bits;   // cs_n, act_n, ras, cas, we, a10
    bank_cmd_t  dec_cmd;

    assign cmd_bits = {cs_n, act_n, addr[16:14], addr[10]};

    // single-edge decode, a10 high (auto precharge / all banks) falls to no command
    always_comb begin
        casez (cmd_bits)
            6'b00????: dec_cmd = CMD_ACTIVATE;
            6'b010100: dec_cmd = CMD_PRECHARGE;
            6'b011000: dec_cmd = CMD_WRITE;
            6'b011010: dec_cmd = CMD_READ;
            default:   dec_cmd = CMD_NONE;   // deselect, nop, refresh and the rest
        endcase
    end

    // control outputs
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            cmd_sel <= '0;
            cmd     <= CMD_NONE;
        end else begin
            cmd <= dec_cmd;
            if (dec_cmd != CMD_NONE) begin
                cmd_sel <= bank_sel_t'(1) << ba;   // the only place ba is turned into a bank
            end else begin
                cmd_sel <= '0;
            end
        end
    end

    // address payload
    always_ff @(posedge clk_in) begin
        if (dec_cmd == CMD_ACTIVATE) begin
            cmd_row <= addr[`DRAM_ROW_BITS-1:0];   // upper row bits not modeled
        end
        if (dec_cmd == CMD_READ || dec_cmd == CMD_WRITE) begin
            cmd_col <= addr[`DRAM_COL_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/dram_write_burst_buffer.sv ====
// write data capture shared by all banks
// after a WRITE it shifts in eight beats of dq_in and dqm_in, then pulses
// wr_commit for the target bank with the whole burst on wr_data/wr_mask
`timescale 1ns/1ps
`default_nettype none

`include "dram_params.svh"

module dram_write_burst_buffer import dram_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_N_in,
    input  bank_sel_t cmd_sel,
    input  bank_cmd_t cmd,
    input  dq_t       dq_in,
    input  dq_t       dqm_in,      // 1 keeps the stored bit
    output bank_sel_t wr_commit,   // one-cycle pulse to the owning bank
    output burst_t    wr_data,
    output burst_t    wr_mask
);

    logic      start;
    logic      busy;
    beat_t     beat_cnt;
    bank_sel_t target;

    // first beat is already on dq_in when the decoded write shows up
    assign start = (cmd == CMD_WRITE) && (cmd_sel != '0);

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            busy      <= 1'b0;
            beat_cnt  <= '0;
            wr_commit <= '0;
        end else begin
            wr_commit <= '0;
            if (start) begin
                busy     <= 1'b1;
                beat_cnt <= beat_t'(1);
            end else if (busy) begin
                beat_cnt <= beat_cnt + beat_t'(1);
                if (beat_cnt == beat_t'(`DRAM_BURST_LEN - 1)) begin
                    busy      <= 1'b0;
                    wr_commit <= target;   // last beat lands this edge
                end
            end
        end
    end

    // shift from the top so beat 0 ends up at index 0
    always_ff @(posedge clk_in) begin
        if (start) begin
            target <= cmd_sel;
        end
        if (start || busy) begin
            wr_data <= {dq_in, wr_data[`DRAM_BURST_LEN-1:1]};
            wr_mask <= {dqm_in, wr_mask[`DRAM_BURST_LEN-1:1]};
        end
    end

    // write bursts must not overlap in the shared buffer
    a_no_write_overlap: assert property (@(posedge clk_in) disable iff (rst_N_in)
        busy |-> !start);

endmodule

`default_nettype wire

// ==== design/dram_bank.sv ====
// one bank: row array, row buffer, latency counter and read burst engine
// reacts only to its own select bit and its own commit pulse from the write buffer
// reads stream 8 beats wrapping inside the aligned group of 8 columns
`timescale 1ns/1ps
`default_nettype none

`include "dram_params.svh"

module dram_bank import dram_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_N_in,
    input  logic      sel,        // this bank's cmd_sel bit
    input  bank_cmd_t cmd,
    input  row_t      cmd_row,
    input  col_t      cmd_col,
    input  logic      commit,     // this bank's wr_commit bit
    input  burst_t    wr_data,
    input  burst_t    wr_mask,
    output logic      rd_valid,   // high through the 8 read beats
    output dq_t       rd_data
);

    dq_t mem [1 << `DRAM_ROW_BITS][1 << `DRAM_COL_BITS];
    dq_t row_buf [1 << `DRAM_COL_BITS];

    bank_state_t state;
    logic [3:0]  lat_cnt;      // counts down latencies and read beats
    row_t        active_row;
    beat_t       rd_beat;      // wraps on its own, giving the burst order
    logic [`DRAM_COL_BITS-$bits(beat_t)-1:0] rd_grp;   // aligned group of the read
    logic [`DRAM_COL_BITS-$bits(beat_t)-1:0] wr_grp;
    dq_t         rd_word;

    logic act_done;
    logic pre_done;
    logic rd_step;
    logic cmd_ok;

    assign act_done = (state == BANK_ACTIVATING) && (lat_cnt == '0);
    assign pre_done = (state == BANK_PRECHARGING) && (lat_cnt == '0);
    // first beat when cas count runs out, the rest while beats remain
    assign rd_step  = (state == BANK_READING) &&
                      (rd_valid ? (lat_cnt != '0) : (lat_cnt == '0));

    // states that can take the command on sel
    assign cmd_ok = (state == BANK_CLOSED && cmd == CMD_ACTIVATE) ||
                    (state == BANK_OPEN && (cmd == CMD_READ || cmd == CMD_WRITE ||
                                            cmd == CMD_PRECHARGE));

    assign rd_data = rd_valid ? rd_word : '0;   // banks are OR-ed at the top

    // bank fsm
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            state    <= BANK_CLOSED;
            lat_cnt  <= '0;
            rd_valid <= 1'b0;
        end else begin
            case (state)
                BANK_CLOSED: begin
                    if (sel && cmd == CMD_ACTIVATE) begin
                        state   <= BANK_ACTIVATING;
                        lat_cnt <= 4'(`DRAM_ACT_LATENCY - 1);
                    end
                end
                BANK_ACTIVATING: begin
                    if (lat_cnt == '0) state <= BANK_OPEN;   // row buffer loaded here
                    else lat_cnt <= lat_cnt - 4'd1;
                end
                BANK_OPEN: begin
                    if (sel) begin
                        case (cmd)
                            CMD_READ: begin
                                state   <= BANK_READING;
                                lat_cnt <= 4'(`DRAM_CAS_LATENCY - 1);
                            end
                            CMD_WRITE: state <= BANK_WRITING;   // wait for the commit
                            CMD_PRECHARGE: begin
                                state   <= BANK_PRECHARGING;
                                lat_cnt <= 4'(`DRAM_PRE_LATENCY - 1);
                            end
                            default: state <= BANK_OPEN;
                        endcase
                    end
                end
                BANK_READING: begin
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 4'd1;
                    end else if (rd_valid) begin
                        rd_valid <= 1'b0;   // last beat went out on the previous edge
                        state    <= BANK_OPEN;
                    end else begin
                        rd_valid <= 1'b1;   // cas latency over, beat 0 now
                        lat_cnt  <= 4'(`DRAM_BURST_LEN - 1);
                    end
                end
                BANK_WRITING: begin
                    if (commit) state <= BANK_OPEN;
                end
                BANK_PRECHARGING: begin
                    if (lat_cnt == '0) state <= BANK_CLOSED;
                    else lat_cnt <= lat_cnt - 4'd1;
                end
                default: state <= BANK_CLOSED;
            endcase
        end
    end

    // array, row buffer and address payload
    always_ff @(posedge clk_in) begin
        if (sel && cmd == CMD_ACTIVATE) active_row <= cmd_row;
        if (sel && cmd == CMD_READ) begin
            rd_beat <= cmd_col[$bits(beat_t)-1:0];            // start column inside group
            rd_grp  <= cmd_col[`DRAM_COL_BITS-1:$bits(beat_t)];
        end
        if (sel && cmd == CMD_WRITE) wr_grp <= cmd_col[`DRAM_COL_BITS-1:$bits(beat_t)];

        if (rd_step) begin
            rd_word <= row_buf[{rd_grp, rd_beat}];
            rd_beat <= rd_beat + beat_t'(1);
        end

        if (act_done) begin
            for (int c = 0; c < (1 << `DRAM_COL_BITS); c++) begin
                row_buf[c] <= mem[active_row][c];   // open the row
            end
        end

        // write beats land in order from the start of the aligned group
        if (commit && state == BANK_WRITING) begin
            for (int k = 0; k < `DRAM_BURST_LEN; k++) begin
                row_buf[{wr_grp, beat_t'(k)}] <= (row_buf[{wr_grp, beat_t'(k)}] & wr_mask[k]) |
                                                 (wr_data[k] & ~wr_mask[k]);
            end
        end

        if (pre_done) begin
            for (int c = 0; c < (1 << `DRAM_COL_BITS); c++) begin
                mem[active_row][c] <= row_buf[c];   // write back on close
            end
        end
    end

    // controller must honour the latencies, nothing here stalls
    a_cmd_legal: assert property (@(posedge clk_in) disable iff (rst_N_in)
        sel |-> cmd_ok);

    // commit belongs to a write this bank accepted earlier
    a_commit_in_write: assert property (@(posedge clk_in) disable iff (rst_N_in)
        commit |-> state == BANK_WRITING);

endmodule

`default_nettype wire

// ==== design/dram_chip.sv ====
// top of the ddr4_lite single-chip model
// decoder feeds the banks and the write buffer, bank read data is OR-merged
// onto dq_out with dq_oe standing in for the tristate enable
`timescale 1ns/1ps
`default_nettype none

`include "dram_params.svh"

module dram_chip import dram_pkg::*; (
    input  logic                       clk_in,
    input  logic                       rst_N_in,
    input  logic                       cs_n,
    input  logic                       act_n,
    input  logic [`DRAM_ADDR_BITS-1:0] addr,
    input  logic [1:0]                 ba,
    input  dq_t                        dq_in,
    input  dq_t                        dqm_in,
    output dq_t                        dq_out,
    output logic                       dq_oe
);

    bank_sel_t cmd_sel;
    bank_cmd_t cmd;
    row_t      cmd_row;
    col_t      cmd_col;
    bank_sel_t wr_commit;
    burst_t    wr_data;
    burst_t    wr_mask;
    logic [`DRAM_NUM_BANKS-1:0] rd_valid;
    dq_t       rd_data [`DRAM_NUM_BANKS];

    dram_cmd_decoder decoder_i (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .cs_n     (cs_n),
        .act_n    (act_n),
        .addr     (addr),
        .ba       (ba),
        .cmd_sel  (cmd_sel),
        .cmd      (cmd),
        .cmd_row  (cmd_row),
        .cmd_col  (cmd_col)
    );

    dram_write_burst_buffer wr_buf_i (
        .clk_in    (clk_in),
        .rst_N_in  (rst_N_in),
        .cmd_sel   (cmd_sel),
        .cmd       (cmd),
        .dq_in     (dq_in),
        .dqm_in    (dqm_in),
        .wr_commit (wr_commit),
        .wr_data   (wr_data),
        .wr_mask   (wr_mask)
    );

    genvar b;
    generate
        for (b = 0; b < `DRAM_NUM_BANKS; b++) begin : g_bank
            dram_bank bank_i (
                .clk_in   (clk_in),
                .rst_N_in (rst_N_in),
                .sel      (cmd_sel[b]),
                .cmd      (cmd),
                .cmd_row  (cmd_row),
                .cmd_col  (cmd_col),
                .commit   (wr_commit[b]),
                .wr_data  (wr_data),
                .wr_mask  (wr_mask),
                .rd_valid (rd_valid[b]),
                .rd_data  (rd_data[b])
            );
        end
    endgenerate

    // idle banks drive zero so a plain OR is enough
    always_comb begin
        dq_out = '0;
        for (int i = 0; i < `DRAM_NUM_BANKS; i++) begin
            dq_out = dq_out | rd_data[i];
        end
    end

    assign dq_oe = |rd_valid;

    // read bursts of different banks must not collide on dq_out
    a_one_reader: assert property (@(posedge clk_in) disable iff (rst_N_in)
        $onehot0(rd_valid));

endmodule

`default_nettype wire

// ==== tests/dram_chip_tb.sv ====
// testbench for the ddr4_lite chip model
// directed and seeded random command traffic with every read beat checked against
// a word-level reference model for its data and its exact arrival time
`timescale 1ns/1ps
`default_nettype none

`include "dram_params.svh"

module dram_chip_tb import dram_pkg::*; ();

    localparam int PERIOD = 4;
    localparam int BL = `DRAM_BURST_LEN;
    localparam int RAND_OPS = 40;
    localparam int DIRECTED_OPS = 40;                             // generous count of the fixed part
    localparam int LONGEST_OP = 1 + `DRAM_CAS_LATENCY + BL;         // a read takes the most cycles
    localparam int WATCHDOG_NS = ((RAND_OPS + DIRECTED_OPS) * LONGEST_OP + 20) * PERIOD;

    logic clk_in = 1'b0;
    logic rst_N_in;
    logic cs_n;
    logic act_n;
    logic [`DRAM_ADDR_BITS-1:0] addr;
    logic [1:0] ba;
    dq_t dq_in;
    dq_t dqm_in;
    dq_t dq_out;
    logic dq_oe;

    integer seed = 67;
    dq_t exp_data [$];              // expected beats with the oldest first
    time exp_time [$];              // sample time of each expected beat
    dq_t ref_mem [int];             // reference words by bank/row/col
    bit  grp_written [int];         // aligned groups holding known data
    int  open_row [`DRAM_NUM_BANKS];
    bit  is_open [`DRAM_NUM_BANKS];
    int  i, bank, col, pick;

    dram_chip dram_chip_i (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .cs_n(cs_n), .act_n(act_n), .addr(addr),
        .ba(ba), .dq_in(dq_in), .dqm_in(dqm_in), .dq_out(dq_out), .dq_oe(dq_oe)
    );

    always #(PERIOD / 2) clk_in = ~clk_in;

    function automatic int word_key(input int b, input int r, input int c);
        return (b * 64 + r) * 16 + c;
    endfunction

    function automatic int group_key(input int b, input int r, input int c);
        return (b * 64 + r) * 2 + c / 8;
    endfunction

    // a mask bit of 1 keeps the stored bit
    function automatic dq_t merge_masked(input dq_t old, input dq_t data, input dq_t mask);
        return (old & mask) | (data & ~mask);
    endfunction

    // beat k of a read wraps inside the aligned group of 8
    function automatic int burst_col(input int start, input int k);
        return (start / 8) * 8 + (start + k) % 8;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic deselect();
        cs_n  <= 1'b1;
        act_n <= 1'b1;
        addr  <= '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_in);
            deselect();
        end
    endtask

    // pins go out on this edge and the DUT samples them on the next
    task automatic drive_cmd(input logic act, input logic [2:0] code, input int b, input int low);
        @(posedge clk_in);
        cs_n  <= 1'b0;
        act_n <= act;
        addr  <= {code, 3'b000, 1'b0, 10'(low)};   // a10 low
        ba    <= 2'(b);
    endtask

    task automatic activate_bank(input int b, input int row);
        drive_cmd(1'b0, 3'b000, b, row);
        is_open[b]  = 1'b1;
        open_row[b] = row;
        idle_cycles(`DRAM_ACT_LATENCY);
    endtask

    task automatic precharge_bank(input int b);
        drive_cmd(1'b1, 3'b010, b, 0);
        is_open[b] = 1'b0;
        idle_cycles(`DRAM_PRE_LATENCY);
    endtask

    // write beats fill the aligned group from its first column
    task automatic write_burst(input int b, input int c, input bit masked);
        int  k;
        int  key;
        dq_t data;
        dq_t mask;
        dq_t old;
        drive_cmd(1'b1, 3'b100, b, c);
        for (k = 0; k < BL; k++) begin
            data = $random(seed);
            mask = masked ? dq_t'($random(seed)) : '0;
            key  = word_key(b, open_row[b], (c / 8) * 8 + k);
            old  = ref_mem.exists(key) ? ref_mem[key] : 'x;
            ref_mem[key] = merge_masked(old, data, mask);
            @(posedge clk_in);
            deselect();
            dq_in  <= data;
            dqm_in <= mask;
        end
        grp_written[group_key(b, open_row[b], c)] = 1'b1;
    endtask

    // rd_valid rises on edge 1+CAS after the sampled command and is seen one edge later
    task automatic issue_read(input int b, input int c);
        int k;
        drive_cmd(1'b1, 3'b101, b, c);
        for (k = 0; k < BL; k++) begin
            exp_data.push_back(ref_mem[word_key(b, open_row[b], burst_col(c, k))]);
            exp_time.push_back($time + (3 + `DRAM_CAS_LATENCY + k) * PERIOD);
        end
    endtask

    task automatic read_burst(input int b, input int c);
        issue_read(b, c);
        idle_cycles(`DRAM_CAS_LATENCY + BL);
    endtask

    // compare every driven beat with the head of the queue
    always @(posedge clk_in) begin
        if (rst_N_in !== 1'b1) begin
            if (dq_oe === 1'b1) begin
                if (exp_data.size() == 0) begin
                    $display("dq_oe went high at %0t with no read beat expected", $time);
                    abort_run();
                end
                check_equal($time, exp_time[0], "beat arrival time");
                check_equal(64'(dq_out), 64'(exp_data[0]), "read data");
                void'(exp_data.pop_front());
                void'(exp_time.pop_front());
            end else if (dq_oe !== 1'b0) begin
                $display("dq_oe is unknown at %0t", $time);
                abort_run();
            end else if (exp_time.size() != 0 && exp_time[0] <= $time) begin
                $display("read beat due at %0t never appeared", exp_time[0]);
                abort_run();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the test did not finish in time");
        abort_run();
    end

    initial begin
        rst_N_in = 1'b1;
        cs_n     = 1'b1;
        act_n    = 1'b1;
        addr     = '0;
        ba       = '0;
        dq_in    = '0;
        dqm_in   = '0;
        repeat (2) @(posedge clk_in);
        rst_N_in <= 1'b0;
        idle_cycles(5);                          // dq_oe must stay low while idle

        activate_bank(0, 3);                     // plain write then wrapped read
        write_burst(0, 0, 1'b0);
        read_burst(0, 5);
        write_burst(0, 0, 1'b1);                 // masked merge over old data
        read_burst(0, 2);

        activate_bank(2, 10);                    // row contents survive a close
        write_burst(2, 8, 1'b0);
        precharge_bank(2);
        activate_bank(2, 20);
        write_burst(2, 8, 1'b0);
        precharge_bank(2);
        activate_bank(2, 10);
        read_burst(2, 13);
        precharge_bank(2);

        precharge_bank(0);                       // two banks with interleaved commands
        activate_bank(0, 5);
        activate_bank(1, 9);
        write_burst(0, 0, 1'b0);
        write_burst(1, 0, 1'b0);
        issue_read(0, 3);
        precharge_bank(1);                       // bank 1 closes while bank 0 bursts
        activate_bank(1, 9);
        issue_read(1, 6);
        idle_cycles(4);
        write_burst(0, 8, 1'b0);                 // bank 0 write under bank 1 burst
        idle_cycles(2);
        read_burst(0, 12);
        read_burst(1, 1);
        precharge_bank(0);
        precharge_bank(1);

        for (i = 0; i < RAND_OPS; i++) begin
            bank = $unsigned($random(seed)) % `DRAM_NUM_BANKS;
            col  = $unsigned($random(seed)) % 16;
            pick = $unsigned($random(seed)) % 4;
            if (!is_open[bank]) begin
                activate_bank(bank, 40 + $unsigned($random(seed)) % 3);
            end else if (pick == 0) begin
                precharge_bank(bank);
            end else if (pick == 1 || !grp_written.exists(group_key(bank, open_row[bank], col))) begin
                write_burst(bank, col, grp_written.exists(group_key(bank, open_row[bank], col)));
            end else begin
                read_burst(bank, col);
            end
        end

        idle_cycles(`DRAM_CAS_LATENCY + BL + 2);
        if (exp_data.size() != 0) begin
            $display("%0d read beats were still outstanding at the end", exp_data.size());
            abort_run();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== ddr4_lite.f ====
+incdir+design
design/dram_pkg.sv
design/dram_cmd_decoder.sv
design/dram_write_burst_buffer.sv
design/dram_bank.sv
design/dram_chip.sv
tests/dram_chip_tb.sv
